// ==== include/mul_config.svh ====
//////////////////////////////
// Multiply unit configuration
// Data width, ROB tag width and
// multiplier pipeline depth
//////////////////////////////

`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// Operand width, RV32 only
`define MUL_XLEN 32

// Reorder-buffer tag width
`define MUL_TAG_W 4

// Multiplier register stages
`define MUL_PIPE_DEPTH 3

// In-flight counter width
// Input reg + pipe stages + two spill entries
`define MUL_CNT_W 3

`endif

// ==== design/mul_op_pkg.sv ====
//////////////////////////////
// Multiply unit operation types
// Opcodes, exception codes, result
// half select and control FSM states
//////////////////////////////

package mul_op_pkg;

  // RV32M multiply opcodes
  // Codes 4 to 7 are illegal for this unit
  typedef enum logic [2:0] {
    MUL_OP_MUL    = 3'd0,
    MUL_OP_MULH   = 3'd1,
    MUL_OP_MULHSU = 3'd2,
    MUL_OP_MULHU  = 3'd3
  } mul_op_e;

  // Exception cause, RISC-V mcause encoding
  typedef logic [3:0] except_code_t;

  // Illegal instruction cause
  localparam except_code_t EXC_ILLEGAL_INSTR = 4'h2;

  // Which product word the last stage returns
  typedef enum logic {
    HALF_LO = 1'b0,
    HALF_HI = 1'b1
  } half_sel_e;

  // Pipeline control FSM
  typedef enum logic [1:0] {
    CTRL_IDLE  = 2'd0,
    CTRL_BUSY  = 2'd1,
    CTRL_FLUSH = 2'd2
  } ctrl_state_e;

endpackage

// ==== design/mul_data_pkg.sv ====
//////////////////////////////
// Multiply unit data types
// Vectors for operands, products
// and reorder-buffer tags
//////////////////////////////

`include "mul_config.svh"

package mul_data_pkg;

  // Architectural register word
  typedef logic [`MUL_XLEN-1:0] word_t;

  // Operand with extra sign bit
  // Lets one signed multiplier cover
  // signed, mixed and unsigned forms
  typedef logic [`MUL_XLEN:0] ext_word_t;

  // Full double-width product
  typedef logic [2*`MUL_XLEN-1:0] prod_t;

  // ROB entry index
  typedef logic [`MUL_TAG_W-1:0] tag_t;

endpackage

// ==== design/mul_ifs.sv ====
//////////////////////////////
// Multiply unit internal buses
// Operand stage bus and the
// result stream with back-pressure
//////////////////////////////

// Operand prep to multiplier pipe
interface mul_stage_if;
  import mul_op_pkg::*;
  import mul_data_pkg::*;

  logic      valid;
  tag_t      tag;
  ext_word_t opa;
  ext_word_t opb;
  half_sel_e half_sel;
  logic      except;

  modport source (output valid, tag, opa, opb, half_sel, except);
  modport sink   (input  valid, tag, opa, opb, half_sel, except);
endinterface

// Multiplier pipe to spill cell
// ready flows back from the spill cell
interface mul_res_if;
  import mul_data_pkg::*;

  logic  valid;
  logic  ready;
  tag_t  tag;
  word_t result;
  logic  except;

  modport source (output valid, tag, result, except, input ready);
  modport sink   (input valid, tag, result, except, output ready);
endinterface

// ==== design/mul_operand_prep.sv ====
//////////////////////////////
// Multiply operand preparation
// Input register, opcode decode and
// operand sign extension
//////////////////////////////

`include "mul_config.svh"

module mul_operand_prep (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     adv_i,
  input  logic                     flush_i,
  input  logic                     valid_i,
  input  mul_op_pkg::mul_op_e      op_i,
  input  mul_data_pkg::tag_t       tag_i,
  input  mul_data_pkg::word_t      rs1_i,
  input  mul_data_pkg::word_t      rs2_i,
  mul_stage_if.source              stage_o
);
  import mul_op_pkg::*;
  import mul_data_pkg::*;

  // Input register
  logic    valid_q;
  mul_op_e op_q;
  tag_t    tag_q;
  word_t   rs1_q;
  word_t   rs2_q;

  // Decode results
  logic      signed_a;
  logic      signed_b;
  half_sel_e half_sel;
  logic      illegal;

  //////////////////////////////
  // Input register
  //////////////////////////////

  // Valid bit, cleared by flush
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (adv_i) begin
      valid_q <= valid_i;
    end
  end

  // Payload, only loaded on an accepted request
  always_ff @(posedge clk_i) begin
    if (adv_i && valid_i) begin
      op_q  <= op_i;
      tag_q <= tag_i;
      rs1_q <= rs1_i;
      rs2_q <= rs2_i;
    end
  end

  //////////////////////////////
  // Opcode decode
  //////////////////////////////

  always_comb begin
    // Unsigned low word by default
    signed_a = 1'b0;
    signed_b = 1'b0;
    half_sel = HALF_LO;
    illegal  = 1'b0;
    case (op_q)
      MUL_OP_MUL: begin
        signed_a = 1'b1;
        signed_b = 1'b1;
      end
      MUL_OP_MULH: begin
        signed_a = 1'b1;
        signed_b = 1'b1;
        half_sel = HALF_HI;
      end
      // rs1 signed, rs2 unsigned
      MUL_OP_MULHSU: begin
        signed_a = 1'b1;
        half_sel = HALF_HI;
      end
      MUL_OP_MULHU: half_sel = HALF_HI;
      // Codes 4 to 7 travel on as exceptions
      default: illegal = 1'b1;
    endcase
  end

  // Extra top bit is the sign or zero
  assign stage_o.valid    = valid_q;
  assign stage_o.tag      = tag_q;
  assign stage_o.opa      = {signed_a & rs1_q[`MUL_XLEN-1], rs1_q};
  assign stage_o.opb      = {signed_b & rs2_q[`MUL_XLEN-1], rs2_q};
  assign stage_o.half_sel = half_sel;
  assign stage_o.except   = illegal;

  // Accepted requests carry a known opcode
  op_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q |-> !$isunknown(op_q));

endmodule

// ==== design/mul_pipe.sv ====
//////////////////////////////
// Pipelined 33x33 multiplier
// Stall-able stages and final
// product half selection
//////////////////////////////

`include "mul_config.svh"

module mul_pipe #(
  parameter int unsigned PIPE_DEPTH = `MUL_PIPE_DEPTH
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       adv_i,
  input  logic       flush_i,
  mul_stage_if.sink  stage_i,
  mul_res_if.source  res_o
);
  import mul_op_pkg::*;
  import mul_data_pkg::*;

  localparam int unsigned XLEN = `MUL_XLEN;
  localparam int unsigned LAST = PIPE_DEPTH - 1;

  // Stage inputs, index 0 fed from the operand stage
  logic      vld_d  [PIPE_DEPTH];
  prod_t     prod_d [PIPE_DEPTH];
  tag_t      tag_d  [PIPE_DEPTH];
  half_sel_e half_d [PIPE_DEPTH];
  logic      exc_d  [PIPE_DEPTH];

  // Stage registers
  logic      vld_q  [PIPE_DEPTH];
  prod_t     prod_q [PIPE_DEPTH];
  tag_t      tag_q  [PIPE_DEPTH];
  half_sel_e half_q [PIPE_DEPTH];
  logic      exc_q  [PIPE_DEPTH];

  // Last stage word
  word_t result;

  //////////////////////////////
  // Multiplier
  //////////////////////////////

  // Signed product of the extended operands
  // Low 2*XLEN bits are exact for all three forms
  assign prod_d[0] = $signed(stage_i.opa) * $signed(stage_i.opb);
  assign vld_d[0]  = stage_i.valid;
  assign tag_d[0]  = stage_i.tag;
  assign half_d[0] = stage_i.half_sel;
  assign exc_d[0]  = stage_i.except;

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  for (genvar i = 0; i < PIPE_DEPTH; i++) begin : gen_stage
    // Chain stage i from stage i-1
    if (i > 0) begin : gen_link
      assign vld_d[i]  = vld_q[i-1];
      assign prod_d[i] = prod_q[i-1];
      assign tag_d[i]  = tag_q[i-1];
      assign half_d[i] = half_q[i-1];
      assign exc_d[i]  = exc_q[i-1];
    end

    // Valid bit, cleared by flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        vld_q[i] <= 1'b0;
      end else if (flush_i) begin
        vld_q[i] <= 1'b0;
      end else if (adv_i) begin
        vld_q[i] <= vld_d[i];
      end
    end

    // Payload moves only on advance
    always_ff @(posedge clk_i) begin
      if (adv_i) begin
        prod_q[i] <= prod_d[i];
        tag_q[i]  <= tag_d[i];
        half_q[i] <= half_d[i];
        exc_q[i]  <= exc_d[i];
      end
    end

    // Stalled stage keeps its item
    stage_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (!adv_i && !flush_i && vld_q[i]) |=>
        (vld_q[i] && $stable(prod_q[i]) && $stable(tag_q[i]) && $stable(exc_q[i])));
  end

  //////////////////////////////
  // Result select
  //////////////////////////////

  always_comb begin
    if (exc_q[LAST]) begin
      // Illegal opcode returns zero
      result = '0;
    end else if (half_q[LAST] == HALF_HI) begin
      result = prod_q[LAST][2*XLEN-1:XLEN];
    end else begin
      result = prod_q[LAST][XLEN-1:0];
    end
  end

  assign res_o.valid  = vld_q[LAST];
  assign res_o.tag    = tag_q[LAST];
  assign res_o.result = result;
  assign res_o.except = exc_q[LAST];

endmodule

// ==== design/mul_spill_cell.sv ====
//////////////////////////////
// Two-entry output spill register
// Main and skid slots, breaks the
// ready path towards the pipe
//////////////////////////////

module mul_spill_cell (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  mul_res_if.sink             res_i,
  output logic                valid_o,
  input  logic                ready_i,
  output mul_data_pkg::tag_t  tag_o,
  output mul_data_pkg::word_t result_o,
  output logic                except_raised_o
);
  import mul_data_pkg::*;

  // Main slot drives the outputs
  logic  main_vld_q;
  tag_t  main_tag_q;
  word_t main_res_q;
  logic  main_exc_q;

  // Skid slot catches one item during a stall
  logic  skid_vld_q;
  tag_t  skid_tag_q;
  word_t skid_res_q;
  logic  skid_exc_q;

  logic in_fire;
  logic out_fire;
  logic main_load;

  // Ready only depends on registered state
  assign res_i.ready = !(main_vld_q && skid_vld_q);
  assign in_fire     = res_i.valid && res_i.ready;
  assign out_fire    = main_vld_q && ready_i;
  // Main slot free or being drained
  assign main_load   = !main_vld_q || out_fire;

  // Slot occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (flush_i) begin
      main_vld_q <= 1'b0;
      skid_vld_q <= 1'b0;
    end else if (main_load) begin
      // Skid item goes first to keep order
      main_vld_q <= skid_vld_q || in_fire;
      skid_vld_q <= 1'b0;
    end else if (in_fire) begin
      skid_vld_q <= 1'b1;
    end
  end

  // Slot payload
  always_ff @(posedge clk_i) begin
    if (main_load) begin
      if (skid_vld_q) begin
        main_tag_q <= skid_tag_q;
        main_res_q <= skid_res_q;
        main_exc_q <= skid_exc_q;
      end else if (in_fire) begin
        main_tag_q <= res_i.tag;
        main_res_q <= res_i.result;
        main_exc_q <= res_i.except;
      end
    end else if (in_fire) begin
      skid_tag_q <= res_i.tag;
      skid_res_q <= res_i.result;
      skid_exc_q <= res_i.except;
    end
  end

  assign valid_o         = main_vld_q;
  assign tag_o           = main_tag_q;
  assign result_o        = main_res_q;
  assign except_raised_o = main_exc_q;

  // Handshake rules towards the ROB side
  valid_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i && !flush_i) |=> valid_o);

  data_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_o && !ready_i && !flush_i) |=>
      ($stable(tag_o) && $stable(result_o) && $stable(except_raised_o)));

endmodule

// ==== design/mul_ctrl.sv ====
//////////////////////////////
// Multiply unit pipeline control
// Advance, ready, flush handling and
// in-flight tracking
//////////////////////////////

`include "mul_config.svh"

module mul_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic flush_i,
  input  logic in_fire_i,
  input  logic out_fire_i,
  input  logic spill_ready_i,
  output logic adv_o,
  output logic ready_o,
  output logic flush_o
);
  import mul_op_pkg::*;

  // Input reg, pipe stages and two spill slots
  localparam int unsigned CNT_MAX = `MUL_PIPE_DEPTH + 3;

  ctrl_state_e           state_q;
  ctrl_state_e           state_d;
  logic [`MUL_CNT_W-1:0] cnt_q;
  logic [`MUL_CNT_W-1:0] cnt_d;

  //////////////////////////////
  // In-flight counter and FSM
  //////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    if (flush_i || (state_q == CTRL_FLUSH)) begin
      cnt_d = '0;
    end else if (in_fire_i && !out_fire_i) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!in_fire_i && out_fire_i) begin
      cnt_d = cnt_q - 1'b1;
    end

    case (state_q)
      // Single recovery cycle
      CTRL_FLUSH: state_d = CTRL_IDLE;
      default:    state_d = (cnt_d == '0) ? CTRL_IDLE : CTRL_BUSY;
    endcase
    if (flush_i) begin
      state_d = CTRL_FLUSH;
    end
  end

  // Leaves reset through the flush state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CTRL_FLUSH;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Whole pipe follows the spill cell
  assign adv_o   = spill_ready_i;
  // No new work in the flush cycle
  assign ready_o = spill_ready_i && (state_q != CTRL_FLUSH);
  // Clears every stage at the next edge
  assign flush_o = flush_i;

  cnt_max_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q <= CNT_MAX);

  // Nothing leaves that never entered
  out_needs_work_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_fire_i && !flush_i) |-> (cnt_q != '0));

endmodule

// ==== design/mul_unit.sv ====
//////////////////////////////
// RV32M multiply execution unit
// Pipelined MUL, MULH, MULHSU, MULHU
// with valid/ready streaming ports
//////////////////////////////

`include "mul_config.svh"

module mul_unit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  // Reservation station side
  input  logic                      valid_i,
  output logic                      ready_o,
  input  mul_op_pkg::mul_op_e       op_i,
  input  mul_data_pkg::tag_t        tag_i,
  input  mul_data_pkg::word_t       rs1_i,
  input  mul_data_pkg::word_t       rs2_i,
  // Result side
  output logic                      valid_o,
  input  logic                      ready_i,
  output mul_data_pkg::tag_t        tag_o,
  output mul_data_pkg::word_t       result_o,
  output logic                      except_raised_o,
  output mul_op_pkg::except_code_t  except_code_o
);
  import mul_op_pkg::*;

  logic adv;
  logic flush_q;
  logic in_fire;
  logic out_fire;

  mul_stage_if stage_if ();
  mul_res_if   res_if ();

  // Handshake events at both ends
  assign in_fire  = valid_i && ready_o;
  assign out_fire = valid_o && ready_i;

  mul_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .in_fire_i     (in_fire),
    .out_fire_i    (out_fire),
    .spill_ready_i (res_if.ready),
    .adv_o         (adv),
    .ready_o       (ready_o),
    .flush_o       (flush_q)
  );

  // Only accepted requests enter the input register
  mul_operand_prep i_prep (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .adv_i   (adv),
    .flush_i (flush_q),
    .valid_i (in_fire),
    .op_i    (op_i),
    .tag_i   (tag_i),
    .rs1_i   (rs1_i),
    .rs2_i   (rs2_i),
    .stage_o (stage_if)
  );

  mul_pipe #(
    .PIPE_DEPTH (`MUL_PIPE_DEPTH)
  ) i_pipe (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .adv_i   (adv),
    .flush_i (flush_q),
    .stage_i (stage_if),
    .res_o   (res_if)
  );

  mul_spill_cell i_spill (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_q),
    .res_i           (res_if),
    .valid_o         (valid_o),
    .ready_i         (ready_i),
    .tag_o           (tag_o),
    .result_o        (result_o),
    .except_raised_o (except_raised_o)
  );

  // Only exception this unit can raise
  assign except_code_o = EXC_ILLEGAL_INSTR;

endmodule

// ==== dv/mul_unit_tb.sv ====
//////////////////////////////
// Multiply unit testbench
// Directed tests against a queue
// based reference model
//////////////////////////////

`include "mul_config.svh"

module mul_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import mul_op_pkg::*;
  import mul_data_pkg::*;

  localparam int XLEN           = `MUL_XLEN;
  localparam int NUM_OPS        = 100 + 1 + 40 + 40 + 16 + 6;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (`MUL_PIPE_DEPTH + 10) + 1000;
  localparam int DRAIN_LIMIT    = 200;
  // Result side ready patterns
  localparam int READY_ALWAYS   = 0;
  localparam int READY_RANDOM   = 1;
  localparam int READY_NEVER    = 2;

  logic         clk_i, rst_ni, flush_i, valid_i, ready_o, valid_o, ready_i;
  logic         except_raised_o;
  mul_op_e      op_i;
  tag_t         tag_i, tag_o;
  word_t        rs1_i, rs2_i, result_o;
  except_code_t except_code_o;

  // Expected results in acceptance order
  tag_t  exp_tag_q [$];
  word_t exp_res_q [$];
  logic  exp_exc_q [$];

  int    seed = 49;
  int    error_cnt, tests_passed, tests_failed, ready_mode, cycle_cnt;
  int    accept_cycle, out_cycle;
  tag_t  next_tag;
  // Last output seen while stalled
  logic  held_valid, held_exc;
  tag_t  held_tag;
  word_t held_res;

  mul_unit i_dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
    .valid_i (valid_i), .ready_o (ready_o), .op_i (op_i), .tag_i (tag_i),
    .rs1_i (rs1_i), .rs2_i (rs2_i), .valid_o (valid_o), .ready_i (ready_i),
    .tag_o (tag_o), .result_o (result_o), .except_raised_o (except_raised_o),
    .except_code_o (except_code_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Run length bound from the op count
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Watchdog expired before the tests completed");
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Reference model and checks
  //////////////////////////////

  // RV32M product, taken mod 2^64
  function automatic word_t model_result(logic [2:0] code, word_t a, word_t b);
    prod_t ea;
    prod_t eb;
    prod_t prod;
    ea = {{XLEN{1'b0}}, a};
    eb = {{XLEN{1'b0}}, b};
    // rs1 signed for MUL, MULH, MULHSU
    if (code <= 3'd2) ea = {{XLEN{a[XLEN-1]}}, a};
    if (code <= 3'd1) eb = {{XLEN{b[XLEN-1]}}, b};
    prod = ea * eb;
    if (code == 3'd0) return prod[XLEN-1:0];
    if (code <= 3'd3) return prod[2*XLEN-1:XLEN];
    return '0;
  endfunction

  task automatic compare_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
      error_cnt++;
    end
  endtask

  task automatic compare_tag(input string name, input tag_t exp, input tag_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
      error_cnt++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
      error_cnt++;
    end
  endtask

  task automatic compare_code(input string name, input except_code_t exp,
                              input except_code_t act);
    if (exp !== act) begin
      $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
      error_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    error_cnt++;
  endtask

  // Pop and compare one delivered result
  task automatic check_result();
    tag_t  etag;
    word_t eres;
    logic  eexc;
    if (exp_tag_q.size() == 0) begin
      report_failure($sformatf("result with tag %h was never requested", tag_o));
    end else begin
      etag = exp_tag_q.pop_front();
      eres = exp_res_q.pop_front();
      eexc = exp_exc_q.pop_front();
      compare_tag("tag_o", etag, tag_o);
      compare_word("result_o", eres, result_o);
      compare_flag("except_raised_o", eexc, except_raised_o);
      if (eexc) compare_code("except_code_o", EXC_ILLEGAL_INSTR, except_code_o);
      out_cycle = cycle_cnt;
    end
  endtask

  //////////////////////////////
  // Cycle driver
  //////////////////////////////

  // One falling edge, result side handled here
  task automatic next_cycle();
    logic [31:0] r;
    logic        rdy;
    @(negedge clk_i);
    cycle_cnt++;
    // A stalled result must not move
    if (held_valid) begin
      if (!valid_o) begin
        report_failure("valid_o fell while ready_i was low");
      end else begin
        compare_tag("tag_o", held_tag, tag_o);
        compare_word("result_o", held_res, result_o);
        compare_flag("except_raised_o", held_exc, except_raised_o);
      end
    end
    r = $random(seed);
    case (ready_mode)
      READY_RANDOM: rdy = (r[1:0] != 2'b00);
      READY_NEVER:  rdy = 1'b0;
      default:      rdy = 1'b1;
    endcase
    ready_i = rdy;
    if (valid_o && rdy) check_result();
    held_valid = valid_o && !rdy;
    held_tag   = tag_o;
    held_res   = result_o;
    held_exc   = except_raised_o;
  endtask

  // Offer one request, hold it until taken
  task automatic send_op(input logic [2:0] code, input word_t a, input word_t b);
    valid_i = 1'b1;
    op_i    = mul_op_e'(code);
    tag_i   = next_tag;
    rs1_i   = a;
    rs2_i   = b;
    while (!ready_o) next_cycle();
    exp_tag_q.push_back(next_tag);
    exp_res_q.push_back(model_result(code, a, b));
    exp_exc_q.push_back(code > 3'd3);
    accept_cycle = cycle_cnt;
    next_tag     = next_tag + 1'b1;
    next_cycle();
  endtask

  // Wait for all expected results, then watch for strays
  task automatic drain();
    int waited;
    valid_i = 1'b0;
    waited  = 0;
    while (exp_tag_q.size() > 0 && waited < DRAIN_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (exp_tag_q.size() > 0) begin
      report_failure($sformatf("%0d results never appeared", exp_tag_q.size()));
      exp_tag_q.delete();
      exp_res_q.delete();
      exp_exc_q.delete();
    end
    repeat (`MUL_PIPE_DEPTH + 4) next_cycle();
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (error_cnt == errs_before) begin
      $display("%s: ok", name);
      tests_passed++;
    end else begin
      $display("%s: %0d errors", name, error_cnt - errs_before);
      tests_failed++;
    end
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    // Control leaves reset through its flush cycle
    compare_flag("ready_o", 1'b0, ready_o);
    compare_flag("valid_o", 1'b0, valid_o);
    next_cycle();
    compare_flag("ready_o", 1'b1, ready_o);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_signedness();
    word_t corners [5];
    int    errs;
    errs    = error_cnt;
    corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
    ready_mode = READY_ALWAYS;
    for (int op = 0; op < 4; op++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) send_op(3'(op), corners[i], corners[j]);
      end
    end
    drain();
    finish_test("test_signedness", errs);
  endtask

  task automatic test_latency();
    int errs;
    errs = error_cnt;
    send_op(3'd0, word_t'($random(seed)), word_t'($random(seed)));
    drain();
    compare_word("valid_o latency", word_t'(`MUL_PIPE_DEPTH + 2),
                 word_t'(out_cycle - accept_cycle));
    finish_test("test_latency", errs);
  endtask

  // Random legal ops, ready_mode picks the output pattern
  task automatic run_random_stream(input int count);
    logic [31:0] r;
    for (int i = 0; i < count; i++) begin
      r = $random(seed);
      send_op({1'b0, r[1:0]}, word_t'($random(seed)), word_t'($random(seed)));
    end
    drain();
  endtask

  task automatic test_stream();
    int errs;
    errs = error_cnt;
    run_random_stream(40);
    finish_test("test_stream", errs);
  endtask

  task automatic test_backpressure();
    int errs;
    errs       = error_cnt;
    ready_mode = READY_RANDOM;
    run_random_stream(40);
    ready_mode = READY_ALWAYS;
    finish_test("test_backpressure", errs);
  endtask

  // Illegal codes interleaved with legal ones
  task automatic test_illegal();
    logic [31:0] r;
    int          errs;
    errs = error_cnt;
    for (int i = 0; i < 16; i++) begin
      r = $random(seed);
      if (i % 2 == 0) send_op(3'(4 + (i / 2) % 4), word_t'($random(seed)), r);
      else send_op({1'b0, r[1:0]}, word_t'($random(seed)), word_t'($random(seed)));
    end
    drain();
    finish_test("test_illegal", errs);
  endtask

  task automatic test_flush();
    int errs;
    errs = error_cnt;
    // Stall the output so work piles up in flight
    ready_mode = READY_NEVER;
    for (int i = 0; i < 5; i++) send_op(3'd1, word_t'($random(seed)), word_t'($random(seed)));
    valid_i = 1'b0;
    flush_i = 1'b1;
    exp_tag_q.delete();
    exp_res_q.delete();
    exp_exc_q.delete();
    held_valid = 1'b0;
    ready_mode = READY_ALWAYS;
    next_cycle();
    flush_i = 1'b0;
    compare_flag("ready_o", 1'b0, ready_o);
    next_cycle();
    compare_flag("ready_o", 1'b1, ready_o);
    send_op(3'd2, word_t'($random(seed)), word_t'($random(seed)));
    drain();
    finish_test("test_flush", errs);
  endtask

  initial begin
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    valid_i    = 1'b0;
    op_i       = MUL_OP_MUL;
    tag_i      = '0;
    rs1_i      = '0;
    rs2_i      = '0;
    ready_i    = 1'b0;
    next_tag   = '0;
    held_valid = 1'b0;
    ready_mode = READY_ALWAYS;
    apply_reset();
    test_signedness();
    test_latency();
    test_stream();
    test_backpressure();
    test_illegal();
    test_flush();
    $display("Tests: %0d passed, %0d failed, %0d errors in total",
             tests_passed, tests_failed, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== mul_unit.f ====
+incdir+include
design/mul_op_pkg.sv
design/mul_data_pkg.sv
design/mul_ifs.sv
design/mul_operand_prep.sv
design/mul_pipe.sv
design/mul_spill_cell.sv
design/mul_ctrl.sv
design/mul_unit.sv
dv/mul_unit_tb.sv
